// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := id_stage_tb
FLIST     := id_stage.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(wildcard hw/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh) $(FLIST)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN) tb/id_stage_golden.hex
	-./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/id_decoder.sv
// Instruction decoder

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0] instr_i,
  input  logic                instr_valid_i,
  output id_pkg::dec_ctrl_t   ctrl_o
);

  import id_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic                funct7_b5;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;
  logic [`ID_XLEN-1:0] imm_b;

  // Instruction fields
  assign opcode    = opcode_e'(instr_i[`ID_OPCODE_W-1:0]);
  assign funct3    = instr_i[`ID_FUNCT3_LSB +: 3];
  // SUB and SRA select bit
  assign funct7_b5 = instr_i[30];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  // Sign bit is always instr[31]
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl_o           = '0;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.op_a_sel  = OP_A_REG;
    ctrl_o.op_b_sel  = OP_B_REG;
    ctrl_o.rs1       = instr_i[`ID_RS1_LSB +: `ID_REG_ADDR_W];
    ctrl_o.rs2       = instr_i[`ID_RS2_LSB +: `ID_REG_ADDR_W];
    ctrl_o.rd        = instr_i[`ID_RD_LSB +: `ID_REG_ADDR_W];
    ctrl_o.jump_kind = JUMP_NONE;
    // Non-jumps still get PC plus I immediate on the target
    ctrl_o.imm       = imm_i;
    ctrl_o.jt_imm    = imm_i;
    ctrl_o.jt_base   = JT_BASE_PC;

    case (opcode)
      OPC_OP:
      begin
        ctrl_o.rd_we = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl_o.alu_op = ALU_SLL;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b011:  ctrl_o.alu_op = ALU_SLTU;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b101:  ctrl_o.alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          default: ctrl_o.alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM:
      begin
        ctrl_o.rd_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        // No SUBI, bit 30 only matters for shifts
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_ADD;
          3'b001:  ctrl_o.alu_op = ALU_SLL;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b011:  ctrl_o.alu_op = ALU_SLTU;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b101:  ctrl_o.alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          default: ctrl_o.alu_op = ALU_AND;
        endcase
      end
      OPC_LUI:
      begin
        // Zero plus U immediate
        ctrl_o.rd_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm      = imm_u;
      end
      OPC_AUIPC:
      begin
        ctrl_o.rd_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm      = imm_u;
      end
      OPC_JAL:
      begin
        // EX computes the link address PC + 4
        ctrl_o.rd_we     = 1'b1;
        ctrl_o.op_a_sel  = OP_A_PC;
        ctrl_o.op_b_sel  = OP_B_PCINCR;
        ctrl_o.jump_kind = JUMP_UNCOND;
        ctrl_o.jt_imm    = imm_j;
      end
      OPC_JALR:
      begin
        ctrl_o.rd_we     = 1'b1;
        ctrl_o.op_a_sel  = OP_A_PC;
        ctrl_o.op_b_sel  = OP_B_PCINCR;
        ctrl_o.jump_kind = JUMP_UNCOND;
        ctrl_o.jt_base   = JT_BASE_RS1;
      end
      OPC_BRANCH:
      begin
        // Operands stay rs1 and rs2 for the compare in EX
        ctrl_o.jump_kind = JUMP_COND;
        ctrl_o.jt_imm    = imm_b;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_BEQ;
          3'b001:  ctrl_o.alu_op = ALU_BNE;
          3'b100:  ctrl_o.alu_op = ALU_BLT;
          3'b101:  ctrl_o.alu_op = ALU_BGE;
          3'b110:  ctrl_o.alu_op = ALU_BLTU;
          3'b111:  ctrl_o.alu_op = ALU_BGEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal instructions neither write nor jump
    if (ctrl_o.illegal)
    begin
      ctrl_o.rd_we     = 1'b0;
      ctrl_o.jump_kind = JUMP_NONE;
    end

    // No instruction in ID, emit a bubble
    if (!instr_valid_i)
    begin
      ctrl_o.rd_we     = 1'b0;
      ctrl_o.jump_kind = JUMP_NONE;
      ctrl_o.illegal   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/id_ex_pipe.sv
// ID/EX pipeline register

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_ex_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall_i,
  input  id_pkg::dec_ctrl_t   ctrl_i,
  input  logic [`ID_XLEN-1:0] operand_a_i,
  input  logic [`ID_XLEN-1:0] operand_b_i,
  output id_pkg::id_ex_t      ex_o
);

  import id_pkg::*;

  // Idle payload, also the reset value
  localparam id_ex_t BUBBLE = '{
    alu_op:    ALU_ADD,
    operand_a: '0,
    operand_b: '0,
    rd:        '0,
    rd_we:     1'b0,
    jump_kind: JUMP_NONE,
    illegal:   1'b0
  };

  logic   is_bubble;
  id_ex_t ex_d;

  // Nothing to write and no jump, or an illegal opcode
  assign is_bubble = ctrl_i.illegal || (!ctrl_i.rd_we && (ctrl_i.jump_kind == JUMP_NONE));

  always_comb
  begin
    ex_d = BUBBLE;
    if (is_bubble)
    begin
      // Only the illegal flag survives into EX
      ex_d.illegal = ctrl_i.illegal;
    end
    else
    begin
      ex_d.alu_op    = ctrl_i.alu_op;
      ex_d.operand_a = operand_a_i;
      ex_d.operand_b = operand_b_i;
      ex_d.rd        = ctrl_i.rd;
      ex_d.rd_we     = ctrl_i.rd_we;
      ex_d.jump_kind = ctrl_i.jump_kind;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ex_o <= BUBBLE;
    else if (!stall_i)
      ex_o <= ex_d;
  end

endmodule

`default_nettype wire

// File: hw/id_operand_sel.sv
// Operand forwarding and selection

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_operand_sel (
  input  id_pkg::dec_ctrl_t   ctrl_i,
  input  logic [`ID_XLEN-1:0] pc_i,
  input  logic [`ID_XLEN-1:0] rdata_a_i,
  input  logic [`ID_XLEN-1:0] rdata_b_i,
  input  id_pkg::reg_wr_t     fw_wr_i,
  input  id_pkg::reg_wr_t     wb_wr_i,
  output logic [`ID_XLEN-1:0] operand_a_o,
  output logic [`ID_XLEN-1:0] operand_b_o,
  output logic [`ID_XLEN-1:0] jump_target_o
);

  import id_pkg::*;

  localparam logic [`ID_XLEN-1:0] PC_INCR = `ID_PC_INCR;

  logic [`ID_XLEN-1:0] rs1_fwd;
  logic [`ID_XLEN-1:0] rs2_fwd;
  logic [`ID_XLEN-1:0] jt_base;

  // ALU result beats writeback, x0 is never forwarded
  function automatic logic [`ID_XLEN-1:0] fwd_value(
    input logic [`ID_REG_ADDR_W-1:0] addr,
    input logic [`ID_XLEN-1:0]       rf_data,
    input reg_wr_t                   fw,
    input reg_wr_t                   wb
  );
    logic [`ID_XLEN-1:0] value;
    if (addr == '0)
      value = '0;
    else if (fw.we && (fw.addr == addr))
      value = fw.data;
    else if (wb.we && (wb.addr == addr))
      value = wb.data;
    else
      value = rf_data;
    return value;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////////////

  assign rs1_fwd = fwd_value(ctrl_i.rs1, rdata_a_i, fw_wr_i, wb_wr_i);
  assign rs2_fwd = fwd_value(ctrl_i.rs2, rdata_b_i, fw_wr_i, wb_wr_i);

  ////////////////////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fwd;
    endcase
  end

  always_comb
  begin
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = ctrl_i.imm;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_fwd;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Jump target
  ////////////////////////////////////////////////////////////////////////////

  // JALR takes raw rs1 to keep the forward muxes off the target adder
  assign jt_base = (ctrl_i.jt_base == JT_BASE_RS1) ? rdata_a_i : pc_i;

  assign jump_target_o = jt_base + ctrl_i.jt_imm;

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
// Decode stage types

`default_nettype none

`include "id_defines.svh"

package id_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [`ID_OPCODE_W-1:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operators, compares last
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
    ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  // Kind of control transfer seen in ID
  typedef enum logic [1:0] {
    JUMP_NONE   = 2'd0,
    JUMP_UNCOND = 2'd1,
    JUMP_COND   = 2'd2
  } jump_kind_e;

  // Operand A sources
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B sources
  typedef enum logic [1:0] {
    OP_B_REG    = 2'd0,
    OP_B_IMM    = 2'd1,
    OP_B_PCINCR = 2'd2
  } op_b_sel_e;

  // Base of the jump target adder
  typedef enum logic {
    JT_BASE_PC  = 1'b0,
    JT_BASE_RS1 = 1'b1
  } jt_base_e;

  // One register write port
  typedef struct packed {
    logic                      we;
    logic [`ID_REG_ADDR_W-1:0] addr;
    logic [`ID_XLEN-1:0]       data;
  } reg_wr_t;

  // Decoded control of the instruction in ID
  typedef struct packed {
    alu_op_e                   alu_op;
    op_a_sel_e                 op_a_sel;
    op_b_sel_e                 op_b_sel;
    logic [`ID_REG_ADDR_W-1:0] rs1;
    logic [`ID_REG_ADDR_W-1:0] rs2;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic                      rd_we;
    jump_kind_e                jump_kind;
    logic                      illegal;
    logic [`ID_XLEN-1:0]       imm;
    logic [`ID_XLEN-1:0]       jt_imm;
    jt_base_e                  jt_base;
  } dec_ctrl_t;

  // ID/EX pipe payload
  typedef struct packed {
    alu_op_e                   alu_op;
    logic [`ID_XLEN-1:0]       operand_a;
    logic [`ID_XLEN-1:0]       operand_b;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic                      rd_we;
    jump_kind_e                jump_kind;
    logic                      illegal;
  } id_ex_t;

endpackage

`default_nettype wire

// File: hw/id_regfile.sv
// Two-write register file

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`ID_XLEN-1:0]       rdata_a_o,
  output logic [`ID_XLEN-1:0]       rdata_b_o,
  input  id_pkg::reg_wr_t           wr_a_i,
  input  id_pkg::reg_wr_t           wr_b_i
);

  // x0 has no storage
  logic [`ID_XLEN-1:0]     regs_q [1:`ID_NUM_REGS-1];
  logic [`ID_NUM_REGS-1:1] hit_a;
  logic [`ID_NUM_REGS-1:1] hit_b;

  // Per-register write decode
  always_comb
  begin
    for (int i = 1; i < `ID_NUM_REGS; i++)
    begin
      hit_a[i] = wr_a_i.we && (wr_a_i.addr == i[`ID_REG_ADDR_W-1:0]);
      hit_b[i] = wr_b_i.we && (wr_b_i.addr == i[`ID_REG_ADDR_W-1:0]);
    end
  end

  for (genvar r = 1; r < `ID_NUM_REGS; r++)
  begin : g_reg
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        regs_q[r] <= '0;
      end
      else if (hit_b[r])
      begin
        // Port B wins on the same address
        regs_q[r] <= wr_b_i.data;
      end
      else if (hit_a[r])
      begin
        regs_q[r] <= wr_a_i.data;
      end
    end
  end

  // Old value on a same-cycle write
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: hw/id_stage.sv
// Decode stage top

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_stage (
  input  logic                clk,
  input  logic                rst_n,

  // From the instruction source
  input  logic [`ID_XLEN-1:0] instr_i,
  input  logic [`ID_XLEN-1:0] pc_i,
  input  logic                instr_valid_i,

  // Back-pressure from EX
  input  logic                stall_ex_i,

  // Register writes from writeback and the ALU
  input  id_pkg::reg_wr_t     wb_wr_i,
  input  id_pkg::reg_wr_t     fw_wr_i,

  // To EX and fetch
  output id_pkg::id_ex_t      ex_o,
  output logic [`ID_XLEN-1:0] jump_target_o,
  output id_pkg::jump_kind_e  jump_in_id_o
);

  import id_pkg::*;

  dec_ctrl_t           dec_ctrl;
  logic [`ID_XLEN-1:0] rf_rdata_a;
  logic [`ID_XLEN-1:0] rf_rdata_b;
  logic [`ID_XLEN-1:0] operand_a;
  logic [`ID_XLEN-1:0] operand_b;

  id_decoder u_decoder (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ctrl_o        (dec_ctrl)
  );

  // Forward path on port B so it wins conflicts
  id_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (dec_ctrl.rs1),
    .raddr_b_i (dec_ctrl.rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wr_a_i    (wb_wr_i),
    .wr_b_i    (fw_wr_i)
  );

  id_operand_sel u_operand_sel (
    .ctrl_i        (dec_ctrl),
    .pc_i          (pc_i),
    .rdata_a_i     (rf_rdata_a),
    .rdata_b_i     (rf_rdata_b),
    .fw_wr_i       (fw_wr_i),
    .wb_wr_i       (wb_wr_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .jump_target_o (jump_target_o)
  );

  id_ex_pipe u_ex_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_ex_i),
    .ctrl_i      (dec_ctrl),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .ex_o        (ex_o)
  );

  // Same-cycle jump indication to fetch
  assign jump_in_id_o = dec_ctrl.jump_kind;

endmodule

`default_nettype wire

// File: id_stage.f
+incdir+include
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_sel.sv
hw/id_ex_pipe.sv
hw/id_stage.sv
tb/id_stage_asserts.sv
tb/id_stage_tb.sv

// File: include/id_defines.svh
// Decode stage widths and field positions

`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Datapath and PC width
`define ID_XLEN         32

// Register file geometry
`define ID_REG_ADDR_W   5
`define ID_NUM_REGS     32

// Link address increment for JAL and JALR
`define ID_PC_INCR      4

// Instruction word field positions
`define ID_OPCODE_W     7
`define ID_RD_LSB       7
`define ID_FUNCT3_LSB   12
`define ID_RS1_LSB      15
`define ID_RS2_LSB      20

`endif

// File: tb/id_stage_asserts.sv
// Decode stage pipe assertions

`default_nettype none
`timescale 1ns/1ns

module id_stage_asserts (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall_ex_i,
  input  id_pkg::id_ex_t ex_i
);

  // Nothing writes back while in reset
  a_reset_no_write: assert property (@(posedge clk) !rst_n |-> !ex_i.rd_we)
    else $error("ex_o.rd_we high during reset");

  // Back-pressure holds the payload
  a_stall_hold: assert property (
    @(posedge clk) disable iff (!rst_n) stall_ex_i |=> $stable(ex_i)
  ) else $error("ex_o changed under stall");

  // Illegal opcodes never write
  a_illegal_no_write: assert property (
    @(posedge clk) disable iff (!rst_n) ex_i.illegal |-> !ex_i.rd_we
  ) else $error("ex_o.illegal with rd_we set");

endmodule

bind id_stage id_stage_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .stall_ex_i (stall_ex_i),
  .ex_i       (ex_o)
);

`default_nettype wire

// File: tb/id_stage_golden.hex
// flags(stall,valid,keep,instr_dc) instr pc wb(we addr data) fw(we addr data) jt jk
// then ex_o: alu_op operand_a operand_b rd rd_we jump_kind illegal
1_00000000_00000000_1_01_11111111_0_00_00000000_00000000_0_0_00000000_00000000_00_0_0_0
1_00000000_00000000_1_02_00000022_0_00_00000000_00000000_0_0_00000000_00000000_00_0_0_0
1_00000000_00000000_1_03_80000000_1_04_00000044_00000000_0_0_00000000_00000000_00_0_0_0
4_002082B3_00000100_0_00_00000000_0_00_00000000_00000102_0_0_11111111_00000022_05_1_0_0
4_40118333_00000104_0_00_00000000_0_00_00000000_00000505_0_1_80000000_11111111_06_1_0_0
4_FFD10393_00000108_0_00_00000000_0_00_00000000_00000105_0_0_00000022_FFFFFFFD_07_1_0_0
4_00008413_0000010C_1_01_BBBBBBBB_1_01_AAAAAAAA_0000010C_0_0_AAAAAAAA_00000000_08_1_0_0
4_003104B3_00000110_1_02_12345678_0_00_00000000_00000113_0_0_12345678_80000000_09_1_0_0
4_00100533_00000114_1_00_CAFEF00D_1_00_DEADBEEF_00000115_0_0_00000000_AAAAAAAA_0A_1_0_0
4_020000EF_00000200_0_00_00000000_0_00_00000000_00000220_1_0_00000200_00000004_01_1_1_0
4_00810067_00000300_0_00_00000000_1_02_99999999_12345680_1_0_00000300_00000004_00_1_1_0
4_FE2088E3_00000400_0_00_00000000_1_01_5555AAAA_000003F0_2_A_5555AAAA_99999999_11_0_2_0
E_12345637_00000500_0_00_00000000_0_00_00000000_00000623_0_0_00000000_00000000_00_0_0_0
4_12345637_00000500_0_00_00000000_0_00_00000000_00000623_0_0_00000000_12345000_0C_1_0_0
1_00000000_00000000_0_00_00000000_0_00_00000000_00000000_0_0_00000000_00000000_00_0_0_0
4_0000000B_00000600_0_00_00000000_0_00_00000000_00000600_0_0_00000000_00000000_00_0_0_1
4_00002083_00000604_0_00_00000000_0_00_00000000_00000604_0_0_00000000_00000000_00_0_0_1
4_00001697_00000700_0_00_00000000_0_00_00000000_00000700_0_0_00000700_00001000_0D_1_0_0
1_00000000_00000000_0_00_00000000_0_00_00000000_00000000_0_0_00000000_00000000_00_0_0_0

// File: tb/id_stage_tb.sv
// Decode stage testbench

`default_nettype none
`timescale 1ns/1ns

`include "id_defines.svh"

module id_stage_tb;

  import id_pkg::*;

  localparam int NUM_VEC     = 19;
  localparam int RESET_CYC   = 10;
  localparam int CYCLE_LIMIT = NUM_VEC + RESET_CYC + 20;
  localparam int SEED        = 35478;

  // One golden line with every field nibble aligned
  typedef struct packed {
    logic        stall;
    logic        valid;
    logic        keep;
    logic        instr_dc;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [3:0]  wb_we;
    logic [7:0]  wb_addr;
    logic [31:0] wb_data;
    logic [3:0]  fw_we;
    logic [7:0]  fw_addr;
    logic [31:0] fw_data;
    logic [31:0] exp_jt;
    logic [3:0]  exp_jk;
    logic [3:0]  exp_alu;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [7:0]  exp_rd;
    logic [3:0]  exp_we;
    logic [3:0]  exp_ex_jk;
    logic [3:0]  exp_ill;
  } golden_vec_t;

  logic                clk;
  logic                rst_n;
  logic [`ID_XLEN-1:0] instr_i;
  logic [`ID_XLEN-1:0] pc_i;
  logic                instr_valid_i;
  logic                stall_ex_i;
  reg_wr_t             wb_wr_i;
  reg_wr_t             fw_wr_i;
  id_ex_t              ex_o;
  logic [`ID_XLEN-1:0] jump_target_o;
  jump_kind_e          jump_in_id_o;

  logic [$bits(golden_vec_t)-1:0] golden_mem [NUM_VEC];
  int                             cycle_cnt;

  id_stage u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .stall_ex_i    (stall_ex_i),
    .wb_wr_i       (wb_wr_i),
    .fw_wr_i       (fw_wr_i),
    .ex_o          (ex_o),
    .jump_target_o (jump_target_o),
    .jump_in_id_o  (jump_in_id_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_ex(input id_ex_t expected);
    compare_value("ex_o.alu_op", 32'(expected.alu_op), 32'(ex_o.alu_op));
    compare_value("ex_o.operand_a", expected.operand_a, ex_o.operand_a);
    compare_value("ex_o.operand_b", expected.operand_b, ex_o.operand_b);
    compare_value("ex_o.rd", 32'(expected.rd), 32'(ex_o.rd));
    compare_value("ex_o.rd_we", 32'(expected.rd_we), 32'(ex_o.rd_we));
    compare_value("ex_o.jump_kind", 32'(expected.jump_kind), 32'(ex_o.jump_kind));
    compare_value("ex_o.illegal", 32'(expected.illegal), 32'(ex_o.illegal));
  endtask

  task automatic drive_vector(input golden_vec_t v);
    stall_ex_i    = v.stall;
    instr_valid_i = v.valid;
    // Don't-care instruction word gets random filler
    instr_i       = v.instr_dc ? $urandom : v.instr;
    pc_i          = v.pc;
    wb_wr_i.we    = v.wb_we[0];
    wb_wr_i.addr  = v.wb_addr[`ID_REG_ADDR_W-1:0];
    wb_wr_i.data  = v.wb_data;
    fw_wr_i.we    = v.fw_we[0];
    fw_wr_i.addr  = v.fw_addr[`ID_REG_ADDR_W-1:0];
    fw_wr_i.data  = v.fw_data;
  endtask

  initial
  begin
    golden_vec_t v;
    id_ex_t      exp_ex;

    cycle_cnt     = 0;
    rst_n         = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    stall_ex_i    = 1'b0;
    wb_wr_i       = '0;
    fw_wr_i       = '0;
    void'($urandom(SEED));
    $readmemh("tb/id_stage_golden.hex", golden_mem);

    repeat (RESET_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset payload is an idle bubble
    exp_ex = '0;
    exp_ex.alu_op    = ALU_ADD;
    exp_ex.jump_kind = JUMP_NONE;
    check_ex(exp_ex);

    for (int i = 0; i < NUM_VEC; i++)
    begin
      v = golden_vec_t'(golden_mem[i]);
      drive_vector(v);

      // Jump outputs settle within the same cycle
      #1;
      if (!v.instr_dc)
      begin
        compare_value("jump_target_o", v.exp_jt, jump_target_o);
        compare_value("jump_in_id_o", 32'(v.exp_jk[1:0]), 32'(jump_in_id_o));
      end

      @(posedge clk);
      #1;
      // A held payload keeps the previous expectation
      if (!v.keep)
      begin
        exp_ex.alu_op    = alu_op_e'(v.exp_alu);
        exp_ex.operand_a = v.exp_a;
        exp_ex.operand_b = v.exp_b;
        exp_ex.rd        = v.exp_rd[`ID_REG_ADDR_W-1:0];
        exp_ex.rd_we     = v.exp_we[0];
        exp_ex.jump_kind = jump_kind_e'(v.exp_ex_jk[1:0]);
        exp_ex.illegal   = v.exp_ill[0];
      end
      check_ex(exp_ex);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
